//--- Bender.yml
package:
  name: prng_clearing

sources:
  - include_dirs:
      - src
    files:
      - src/prng_clearing_pkg.sv
      - src/entropy_buffer.sv
      - src/clearing_lfsr.sv
      - src/prng_clearing.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/prng_clearing_assertions.sv
      - tb/tb_prng_clearing.sv

//--- src.f
+incdir+src
src/prng_clearing_pkg.sv
src/entropy_buffer.sv
src/clearing_lfsr.sv
src/prng_clearing.sv
tb/prng_clearing_assertions.sv
tb/tb_prng_clearing.sv

//--- src/clearing_lfsr.sv
/*
 * Clearing LFSR
 * 64-bit Galois XOR LFSR with seed load and zero-seed guard
 * Output goes through a permutation, PRINCE S-boxes and a second permutation
 */

`include "prng_clearing_macros.svh"

module clearing_lfsr (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Seed load, takes priority over stepping
  input  logic                          seed_en_i,
  input  prng_clearing_pkg::seed_word_u seed_i,

  // Step enable
  input  logic                          lfsr_en_i,

  // Nonlinear output word
  output prng_clearing_pkg::prng_word_t rand_o
);

  localparam int unsigned NumNibbles = `PRNG_WIDTH / 4;

  prng_clearing_pkg::prng_word_t state_d, state_q;

  // Next state for one Galois step
  prng_clearing_pkg::prng_word_t step_state;

  // Seed after the zero check
  prng_clearing_pkg::prng_word_t load_state;

  // Output network stages
  prng_clearing_pkg::prng_word_t perm_state;
  prng_clearing_pkg::prng_word_t sbox_state;

  // Shift right, fold the dropped bit back in through the tap mask
  always_comb begin
    step_state = {1'b0, state_q[`PRNG_WIDTH-1:1]};
    if (state_q[0]) begin
      step_state = step_state ^ `PRNG_LFSR_POLY;
    end
  end

  // All-zero state would lock up the LFSR
  always_comb begin
    load_state = seed_i.word;
    if (seed_i.word == '0) begin
      load_state = `PRNG_DEFAULT_SEED;
    end
  end

  // Load wins over step
  // Top level never raises both together anyway
  always_comb begin
    state_d = state_q;
    if (seed_en_i) begin
      state_d = load_state;
    end else if (lfsr_en_i) begin
      state_d = step_state;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= `PRNG_DEFAULT_SEED;
    end else begin
      state_q <= state_d;
    end
  end

  // Spread neighbouring state bits over different S-boxes
  assign perm_state = prng_clearing_pkg::bit_permute(state_q, `PRNG_STATE_PERM_MULT);

  // Nonlinear layer, one PRINCE S-box per nibble
  for (genvar n = 0; n < NumNibbles; n++) begin : gen_sbox
    assign sbox_state[4*n +: 4] = prng_clearing_pkg::prince_sbox(perm_state[4*n +: 4]);
  end

  // Mix the S-box outputs across the word
  assign rand_o = prng_clearing_pkg::bit_permute(sbox_state, `PRNG_OUT_PERM_MULT);

endmodule

//--- src/entropy_buffer.sv
/*
 * Entropy buffer
 * Joins two 32-bit entropy words into one 64-bit seed
 * and flags the seed as valid together with the second word
 */

module entropy_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Entropy handshake, request comes from the top level
  input  logic                            entropy_req_i,
  input  logic                            entropy_ack_i,
  input  prng_clearing_pkg::entropy_word_t entropy_i,

  // Seed towards the LFSR
  output prng_clearing_pkg::seed_word_u   seed_o,
  output logic                            seed_valid_o
);

  // Upper half of the seed, waiting for the second word
  prng_clearing_pkg::entropy_word_t half_q;

  // Set once the upper half is held
  logic half_valid_d, half_valid_q;

  // Ack counts only while entropy is actually requested
  logic accept;

  // Stray acks without a request are dropped here
  assign accept = entropy_req_i & entropy_ack_i;

  // First accepted word sets the flag, second one clears it
  always_comb begin
    half_valid_d = half_valid_q;
    if (accept) begin
      half_valid_d = ~half_valid_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_valid_q <= 1'b0;
    end else begin
      half_valid_q <= half_valid_d;
    end
  end

  // Only the first word of a pair is stored
  always_ff @(posedge clk_i) begin
    if (accept && !half_valid_q) begin
      half_q <= entropy_i;
    end
  end

  // Seed is complete in the cycle of the second accepted word
  assign seed_valid_o = accept & half_valid_q;

  // Stored word on top, live word below
  always_comb begin
    seed_o.halves.hi = half_q;
    seed_o.halves.lo = entropy_i;
  end

endmodule

//--- src/prng_clearing.sv
/*
 * Clearing PRNG top level
 * Arbitrates data against reseed requests and supplies two wipe shares
 * Share 1 is a fixed bit permutation of share 0
 */

`include "prng_clearing_macros.svh"

module prng_clearing (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Wipe data consumer
  input  logic                             data_req_i,
  output logic                             data_ack_o,
  output prng_clearing_pkg::prng_word_t    data_share0_o,
  output prng_clearing_pkg::prng_word_t    data_share1_o,

  // Reseed request from the consumer
  input  logic                             reseed_req_i,
  output logic                             reseed_ack_o,

  // Entropy source
  output logic                             entropy_req_o,
  input  logic                             entropy_ack_i,
  input  prng_clearing_pkg::entropy_word_t entropy_i
);

  // Seed from the buffer and its strobe
  prng_clearing_pkg::seed_word_u seed;
  logic                          seed_valid;

  // LFSR controls
  logic lfsr_en;
  logic seed_en;

  // Reseed has priority
  // Data is held off for the whole reseed
  assign data_ack_o = data_req_i & ~reseed_req_i;

  // One step per accepted data word
  assign lfsr_en = data_ack_o;

  // Entropy is requested as long as the reseed is pending
  assign entropy_req_o = reseed_req_i;

  // Seed load and reseed ack share the second-word strobe
  assign seed_en      = seed_valid;
  assign reseed_ack_o = seed_valid;

  // Pairs up the two entropy words
  entropy_buffer u_entropy_buffer (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .entropy_req_i ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     ),
    .seed_o        ( seed          ),
    .seed_valid_o  ( seed_valid    )
  );

  // LFSR with its nonlinear output network
  clearing_lfsr u_clearing_lfsr (
    .clk_i     ( clk_i         ),
    .rst_ni    ( rst_ni        ),
    .seed_en_i ( seed_en       ),
    .seed_i    ( seed          ),
    .lfsr_en_i ( lfsr_en       ),
    .rand_o    ( data_share0_o )
  );

  // Second share for masked key and state registers
  // Fixed wiring, no extra logic
  assign data_share1_o =
    prng_clearing_pkg::bit_permute(data_share0_o, `PRNG_SHARE_PERM_MULT);

endmodule

//--- src/prng_clearing_macros.svh
/*
 * Clearing PRNG constants
 * Widths, reset seed, LFSR feedback mask and permutation multipliers
 */

`ifndef PRNG_CLEARING_MACROS_SVH
`define PRNG_CLEARING_MACROS_SVH

// Width of the LFSR state and of each wipe share
`define PRNG_WIDTH 64

// One entropy word, half of the LFSR width
`define ENTROPY_WIDTH 32

// State after reset, also used in place of an all-zero seed
`define PRNG_DEFAULT_SEED 64'hc851_f9a2_367e_0db4

// Galois feedback mask for x^64 + x^63 + x^61 + x^60 + 1
// Taps sit on bits 63, 62, 60 and 59 of the right-shifting state
`define PRNG_LFSR_POLY 64'hd800_0000_0000_0000

// Aligned permutation in front of the S-box layer
// Output bit (i * mult) mod 64 takes input bit i
`define PRNG_STATE_PERM_MULT 13

// Permutation behind the S-box layer, same rule
`define PRNG_OUT_PERM_MULT 7

// Share 1 is share 0 permuted with this multiplier
`define PRNG_SHARE_PERM_MULT 29

`endif

//--- src/prng_clearing_pkg.sv
/*
 * Clearing PRNG package
 * Word types, the seed union, the PRINCE S-box and the bit permutation
 */

`include "prng_clearing_macros.svh"

package prng_clearing_pkg;

  // LFSR state and one wipe share
  typedef logic [`PRNG_WIDTH-1:0] prng_word_t;

  // One word from the entropy source
  typedef logic [`ENTROPY_WIDTH-1:0] entropy_word_t;

  // Single S-box input or output
  typedef logic [3:0] nibble_t;

  // Seed as seen by the entropy buffer
  // First entropy word lands in the upper half
  typedef struct packed {
    entropy_word_t hi;
    entropy_word_t lo;
  } seed_halves_t;

  // Buffer writes the halves, the LFSR reads the whole word
  typedef union packed {
    prng_word_t   word;
    seed_halves_t halves;
  } seed_word_u;

  // PRINCE S-box, entry 0 in the lowest nibble
  // Forward order B F 3 2 A C 9 1 6 7 8 0 E 5 D 4
  localparam logic [15:0][3:0] prince_sbox_table = {
    4'h4, 4'hd, 4'h5, 4'he,
    4'h0, 4'h8, 4'h7, 4'h6,
    4'h1, 4'h9, 4'hc, 4'ha,
    4'h2, 4'h3, 4'hf, 4'hb
  };

  // Nonlinear map of one nibble
  function automatic nibble_t prince_sbox(nibble_t in_nibble);
    return prince_sbox_table[in_nibble];
  endfunction

  // Aligned bit permutation
  // An odd multiplier is coprime to 64, so every target bit is hit once
  function automatic prng_word_t bit_permute(prng_word_t in_word, int unsigned mult);
    prng_word_t out_word;
    out_word = '0;
    for (int unsigned i = 0; i < `PRNG_WIDTH; i++) begin
      out_word[(i * mult) % `PRNG_WIDTH] = in_word[i];
    end
    return out_word;
  endfunction

endpackage

//--- tb/prng_clearing_assertions.sv
/*
 * Clearing PRNG protocol assertions
 * Bound into the top level to watch the request and acknowledge rules
 */

module prng_clearing_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          data_req_i,
  input logic                          data_ack_o,
  input logic                          reseed_req_i,
  input logic                          reseed_ack_o,
  input logic                          entropy_req_o,
  input logic                          entropy_ack_i,
  input prng_clearing_pkg::prng_word_t data_share0_o,
  input prng_clearing_pkg::prng_word_t data_share1_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions so far
  int unsigned failures = 0;

  // Data ack only for a request with no reseed pending
  data_ack_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_ack_o |-> (data_req_i && !reseed_req_i))
  else begin
    $error("data_ack_o high without a grantable data request");
    failures++;
  end

  // Reseed ack is tied to the second entropy strobe
  reseed_ack_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reseed_ack_o |-> entropy_ack_i)
  else begin
    $error("reseed_ack_o high without entropy_ack_i");
    failures++;
  end

  // Entropy request mirrors the reseed request
  entropy_req_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy_req_o == reseed_req_i)
  else begin
    $error("entropy_req_o differs from reseed_req_i");
    failures++;
  end

  // No X or Z on any output once out of reset
  known_outputs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({data_ack_o, reseed_ack_o, entropy_req_o, data_share0_o, data_share1_o}))
  else begin
    $error("DUT output is unknown");
    failures++;
  end

endmodule

bind prng_clearing prng_clearing_assertions u_prng_clearing_assertions (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .data_req_i    ( data_req_i    ),
  .data_ack_o    ( data_ack_o    ),
  .reseed_req_i  ( reseed_req_i  ),
  .reseed_ack_o  ( reseed_ack_o  ),
  .entropy_req_o ( entropy_req_o ),
  .entropy_ack_i ( entropy_ack_i ),
  .data_share0_o ( data_share0_o ),
  .data_share1_o ( data_share1_o )
);

//--- tb/tb_prng_clearing.sv
/*
 * Clearing PRNG testbench
 * Random data traffic and reseeds checked against a reference model
 */

`include "prng_clearing_macros.svh"

module tb_prng_clearing;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 4;
  localparam int random_cycles = 200;
  localparam int max_gap       = 7;
  localparam int resume_cycles = 12;
  // Odd count, a buffer that took them would be left half filled
  localparam int stray_cycles  = 7;
  localparam int num_reseeds   = 6;
  localparam int ack_timeout   = 4;
  // Worst case per reseed: two gaps, two acks, the wait and the resume phase
  localparam int reseed_cycles = 2 * max_gap + 4 + resume_cycles;
  localparam int total_cycles  = reset_cycles + 4 + random_cycles + stray_cycles
                                 + num_reseeds * reseed_cycles;
  localparam int watchdog_ns   = total_cycles * clk_period * 3 / 2;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             data_req_i;
  logic                             data_ack_o;
  prng_clearing_pkg::prng_word_t    data_share0_o;
  prng_clearing_pkg::prng_word_t    data_share1_o;
  logic                             reseed_req_i;
  logic                             reseed_ack_o;
  logic                             entropy_req_o;
  logic                             entropy_ack_i;
  prng_clearing_pkg::entropy_word_t entropy_i;

  integer      rng_seed;
  int unsigned transfer_count;
  logic        check_en;

  // Reference model: LFSR state plus its own copy of the entropy pairing
  prng_clearing_pkg::prng_word_t    model_state;
  prng_clearing_pkg::entropy_word_t model_half;
  logic                             model_half_valid;

  prng_clearing u_prng_clearing (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .data_req_i    ( data_req_i    ),
    .data_ack_o    ( data_ack_o    ),
    .data_share0_o ( data_share0_o ),
    .data_share1_o ( data_share1_o ),
    .reseed_req_i  ( reseed_req_i  ),
    .reseed_ack_o  ( reseed_ack_o  ),
    .entropy_req_o ( entropy_req_o ),
    .entropy_ack_i ( entropy_ack_i ),
    .entropy_i     ( entropy_i     )
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  // PRINCE S-box, forward order B F 3 2 A C 9 1 6 7 8 0 E 5 D 4
  function automatic logic [3:0] sbox_nibble(input logic [3:0] in_nibble);
    case (in_nibble)
      4'h0: return 4'hb;
      4'h1: return 4'hf;
      4'h2: return 4'h3;
      4'h3: return 4'h2;
      4'h4: return 4'ha;
      4'h5: return 4'hc;
      4'h6: return 4'h9;
      4'h7: return 4'h1;
      4'h8: return 4'h6;
      4'h9: return 4'h7;
      4'ha: return 4'h8;
      4'hb: return 4'h0;
      4'hc: return 4'he;
      4'hd: return 4'h5;
      4'he: return 4'hd;
      default: return 4'h4;
    endcase
  endfunction

  // Bit i moves to position (i * mult) mod 64
  function automatic prng_clearing_pkg::prng_word_t permute_bits(
    input prng_clearing_pkg::prng_word_t in_word, input int mult);
    prng_clearing_pkg::prng_word_t out_word;
    out_word = '0;
    for (int i = 0; i < `PRNG_WIDTH; i++) begin
      out_word[(i * mult) % `PRNG_WIDTH] = in_word[i];
    end
    return out_word;
  endfunction

  // One Galois step, right shift with feedback on the dropped bit
  function automatic prng_clearing_pkg::prng_word_t model_step(
    input prng_clearing_pkg::prng_word_t state);
    prng_clearing_pkg::prng_word_t next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ `PRNG_LFSR_POLY;
    end
    return next;
  endfunction

  // Zero seed falls back to the default seed
  function automatic prng_clearing_pkg::prng_word_t load_seed(
    input prng_clearing_pkg::prng_word_t seed);
    return (seed == '0) ? `PRNG_DEFAULT_SEED : seed;
  endfunction

  // Expected shares for a given LFSR state
  function automatic void model_output(input prng_clearing_pkg::prng_word_t state,
                                       output prng_clearing_pkg::prng_word_t share0,
                                       output prng_clearing_pkg::prng_word_t share1);
    prng_clearing_pkg::prng_word_t mixed;
    prng_clearing_pkg::prng_word_t subst;
    mixed = permute_bits(state, `PRNG_STATE_PERM_MULT);
    for (int n = 0; n < `PRNG_WIDTH / 4; n++) begin
      subst[4*n +: 4] = sbox_nibble(mixed[4*n +: 4]);
    end
    share0 = permute_bits(subst, `PRNG_OUT_PERM_MULT);
    share1 = permute_bits(share0, `PRNG_SHARE_PERM_MULT);
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = $random(rng_seed);
    return r[0];
  endfunction

  function automatic prng_clearing_pkg::entropy_word_t random_word();
    return $random(rng_seed);
  endfunction

  function automatic int random_gap();
    logic [31:0] r;
    r = $random(rng_seed);
    return int'(r % (max_gap + 1));
  endfunction

  task automatic report_failure();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_word(input string name, input prng_clearing_pkg::prng_word_t got,
                            input prng_clearing_pkg::prng_word_t expected);
    if (got !== expected) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
      report_failure();
    end
  endtask

  task automatic check_entropy_req(input logic got, input logic expected);
    if (got !== expected) begin
      $display("[FAIL] entropy_req_o got 0x%h expected 0x%h", got, expected);
      report_failure();
    end
  endtask

  // Compare on every rising edge, then advance the model
  always @(posedge clk_i) begin : compare_outputs
    prng_clearing_pkg::prng_word_t exp_share0;
    prng_clearing_pkg::prng_word_t exp_share1;
    logic exp_data_ack;
    logic exp_reseed_ack;
    if (check_en) begin
      exp_data_ack   = data_req_i & ~reseed_req_i;
      exp_reseed_ack = reseed_req_i & entropy_ack_i & model_half_valid;
      model_output(model_state, exp_share0, exp_share1);
      check_bit("data_ack_o", data_ack_o, exp_data_ack);
      check_bit("reseed_ack_o", reseed_ack_o, exp_reseed_ack);
      check_entropy_req(entropy_req_o, reseed_req_i);
      check_word("data_share0_o", data_share0_o, exp_share0);
      check_word("data_share1_o", data_share1_o, exp_share1);
      if (exp_data_ack) begin
        model_state = model_step(model_state);
        transfer_count++;
      end
      // Acks without a pending reseed never reach the model
      if (reseed_req_i && entropy_ack_i) begin
        if (model_half_valid) begin
          model_state      = load_seed({model_half, entropy_i});
          model_half_valid = 1'b0;
        end else begin
          model_half       = entropy_i;
          model_half_valid = 1'b1;
        end
      end
    end
  end

  // Random gap during a reseed, shares must not move
  task automatic hold_for_gap(input prng_clearing_pkg::prng_word_t held);
    int gap;
    gap = random_gap();
    repeat (gap) begin
      @(negedge clk_i);
      check_word("data_share0_o", data_share0_o, held);
    end
  endtask

  task automatic wait_reseed_ack();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (!reseed_ack_o) begin
      waited++;
      if (waited >= ack_timeout) begin
        $display("reseed_ack_o never came after the second entropy word");
        report_failure();
      end
      @(posedge clk_i);
    end
  endtask

  task automatic random_data_phase(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_i);
      data_req_i    = random_bit();
      // Occasional stray entropy acks with no reseed pending
      entropy_ack_i = random_bit() & random_bit();
      entropy_i     = random_word();
    end
    @(negedge clk_i);
    data_req_i    = 1'b0;
    entropy_ack_i = 1'b0;
  endtask

  task automatic stray_acks(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_i);
      entropy_ack_i = 1'b1;
      entropy_i     = random_word();
    end
    @(negedge clk_i);
    entropy_ack_i = 1'b0;
  endtask

  // Full reseed, then a short data phase
  task automatic reseed_with(input prng_clearing_pkg::entropy_word_t hi,
                             input prng_clearing_pkg::entropy_word_t lo,
                             input logic hold_data);
    prng_clearing_pkg::prng_word_t held_share;
    prng_clearing_pkg::prng_word_t exp_share0;
    prng_clearing_pkg::prng_word_t exp_share1;
    int unsigned transfers_before;
    @(negedge clk_i);
    reseed_req_i  = 1'b1;
    data_req_i    = hold_data;
    entropy_ack_i = 1'b0;
    held_share    = data_share0_o;
    hold_for_gap(held_share);
    entropy_ack_i = 1'b1;
    entropy_i     = hi;
    @(negedge clk_i);
    entropy_ack_i = 1'b0;
    entropy_i     = random_word();
    check_word("data_share0_o", data_share0_o, held_share);
    hold_for_gap(held_share);
    entropy_ack_i = 1'b1;
    entropy_i     = lo;
    wait_reseed_ack();
    @(negedge clk_i);
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
    // Seeded word, first entropy word on top
    model_output(load_seed({hi, lo}), exp_share0, exp_share1);
    check_word("data_share0_o", data_share0_o, exp_share0);
    check_word("data_share1_o", data_share1_o, exp_share1);
    transfers_before = transfer_count;
    for (int c = 0; c < resume_cycles; c++) begin
      data_req_i = hold_data | random_bit();
      @(negedge clk_i);
    end
    data_req_i = 1'b0;
    if (hold_data && transfer_count == transfers_before) begin
      $display("Data transfers did not resume after the reseed");
      report_failure();
    end
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    report_failure();
  end

  initial begin : stimulus
    prng_clearing_pkg::prng_word_t exp_share0;
    prng_clearing_pkg::prng_word_t exp_share1;
    rng_seed         = 32'ha3ee92b6;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    data_req_i       = 1'b0;
    reseed_req_i     = 1'b0;
    entropy_ack_i    = 1'b0;
    entropy_i        = '0;
    transfer_count   = 0;
    check_en         = 1'b0;
    model_state      = `PRNG_DEFAULT_SEED;
    model_half       = '0;
    model_half_valid = 1'b0;

    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // State right after reset
    model_output(`PRNG_DEFAULT_SEED, exp_share0, exp_share1);
    check_word("data_share0_o", data_share0_o, exp_share0);
    check_word("data_share1_o", data_share1_o, exp_share1);
    check_bit("data_ack_o", data_ack_o, 1'b0);
    check_bit("reseed_ack_o", reseed_ack_o, 1'b0);
    check_entropy_req(entropy_req_o, 1'b0);
    check_en = 1'b1;

    random_data_phase(random_cycles);
    for (int r = 0; r < 3; r++) begin
      reseed_with(random_word(), random_word(), 1'b0);
    end
    // Data held high across the whole reseed
    reseed_with(random_word(), random_word(), 1'b1);
    // All-zero seed maps to the default seed
    reseed_with('0, '0, 1'b0);
    // Stray acks must not fill the upper half
    stray_acks(stray_cycles);
    reseed_with(random_word(), random_word(), 1'b0);

    @(negedge clk_i);
    @(negedge clk_i);
    if (u_prng_clearing.u_prng_clearing_assertions.failures == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times",
               u_prng_clearing.u_prng_clearing_assertions.failures);
      report_failure();
    end
  end

endmodule
